/* common/fifo_pkg.sv */
package fifo_pkg;

  localparam int data_width   = 8;
  localparam int fifo_depth   = 16;
  localparam int addr_width   = $clog2(fifo_depth);
  localparam int afull_level  = fifo_depth - 1;
  localparam int aempty_level = 1;

  typedef logic [data_width-1:0] data_t;

  // one extra bit tells a wrapped pointer from an unwrapped one.
  typedef logic [addr_width:0] ptr_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[addr_width] = gray[addr_width];
    for (int i = addr_width - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* rtl/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram (
  input  logic                          wr_clk,
  input  logic                          wr_vld,
  input  logic [fifo_pkg::addr_width-1:0] wr_addr,
  input  fifo_pkg::data_t               wr_data,
  input  logic                          rd_clk,
  input  logic                          rst_n,
  input  logic                          rd_vld,
  input  logic [fifo_pkg::addr_width-1:0] rd_addr,
  output fifo_pkg::data_t               rd_data
);

  fifo_pkg::data_t mem [fifo_pkg::fifo_depth];

  // write port.
  always_ff @(posedge wr_clk) begin
    if (wr_vld) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port, the word is registered on the edge that accepts the read.
  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_vld) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* async_fifo/fifo_wr_ctrl.sv */
`timescale 1ns/1ps

module fifo_wr_ctrl (
  input  logic                            wr_clk,
  input  logic                            rst_n,
  input  logic                            wr_en,
  input  fifo_pkg::ptr_t                  rd_gray,
  output logic                            wr_vld,
  output logic [fifo_pkg::addr_width-1:0] wr_addr,
  output fifo_pkg::ptr_t                  wr_gray,
  output fifo_pkg::wr_status_t            wr_status
);

  localparam int top = fifo_pkg::addr_width;

  fifo_pkg::ptr_t       wr_bin;
  fifo_pkg::ptr_t       wr_bin_nxt;
  fifo_pkg::ptr_t       wr_gray_nxt;
  fifo_pkg::ptr_t       rd_gray_s1;
  fifo_pkg::ptr_t       rd_gray_s2;
  fifo_pkg::ptr_t       rd_bin_sync;
  fifo_pkg::ptr_t       full_gray;
  fifo_pkg::ptr_t       wr_fill;
  fifo_pkg::wr_status_t wr_status_nxt;

  assign wr_vld  = wr_en & ~wr_status.full;
  assign wr_addr = wr_bin[fifo_pkg::addr_width-1:0];

  assign wr_bin_nxt  = wr_bin + fifo_pkg::ptr_t'(wr_vld);
  assign wr_gray_nxt = fifo_pkg::bin2gray(wr_bin_nxt);

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
    end
  end

  // two-flop synchronizer for the read pointer.
  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  assign rd_bin_sync = fifo_pkg::gray2bin(rd_gray_s2);

  // full when the write pointer is one lap ahead of the read pointer.
  assign full_gray = {~rd_gray_s2[top:top-1], rd_gray_s2[top-2:0]};
  assign wr_fill   = wr_bin_nxt - rd_bin_sync;

  assign wr_status_nxt.full  = (wr_gray_nxt == full_gray);
  assign wr_status_nxt.afull = (wr_fill >= fifo_pkg::ptr_t'(fifo_pkg::afull_level));

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      wr_status <= '0;
    end else begin
      wr_status <= wr_status_nxt;
    end
  end

  // no write may slip through while the FIFO is full.
  a_no_adv_full: assert property (
    @(posedge wr_clk) disable iff (!rst_n)
    wr_status.full |=> $stable(wr_bin)
  );

  // the read side samples this pointer, so only one bit may move at a time.
  a_wr_gray_step: assert property (
    @(posedge wr_clk) disable iff (!rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1
  );

endmodule

/* async_fifo/fifo_rd_ctrl.sv */
`timescale 1ns/1ps

module fifo_rd_ctrl (
  input  logic                            rd_clk,
  input  logic                            rst_n,
  input  logic                            rd_en,
  input  fifo_pkg::ptr_t                  wr_gray,
  output logic                            rd_vld,
  output logic [fifo_pkg::addr_width-1:0] rd_addr,
  output fifo_pkg::ptr_t                  rd_gray,
  output fifo_pkg::rd_status_t            rd_status
);

  fifo_pkg::ptr_t       rd_bin;
  fifo_pkg::ptr_t       rd_bin_nxt;
  fifo_pkg::ptr_t       rd_gray_nxt;
  fifo_pkg::ptr_t       wr_gray_s1;
  fifo_pkg::ptr_t       wr_gray_s2;
  fifo_pkg::ptr_t       wr_bin_sync;
  fifo_pkg::ptr_t       rd_fill;
  fifo_pkg::rd_status_t rd_status_nxt;

  assign rd_vld  = rd_en & ~rd_status.empty;
  assign rd_addr = rd_bin[fifo_pkg::addr_width-1:0];

  assign rd_bin_nxt  = rd_bin + fifo_pkg::ptr_t'(rd_vld);
  assign rd_gray_nxt = fifo_pkg::bin2gray(rd_bin_nxt);

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  // two-flop synchronizer for the write pointer.
  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign wr_bin_sync = fifo_pkg::gray2bin(wr_gray_s2);

  // the fill count here lags real writes, so the flags err on the safe side.
  assign rd_fill = wr_bin_sync - rd_bin_nxt;

  assign rd_status_nxt.empty  = (rd_gray_nxt == wr_gray_s2);
  assign rd_status_nxt.aempty = (rd_fill <= fifo_pkg::ptr_t'(fifo_pkg::aempty_level));

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
    end else begin
      rd_status <= rd_status_nxt;
    end
  end

  // no read may slip through while the FIFO is empty.
  a_no_adv_empty: assert property (
    @(posedge rd_clk) disable iff (!rst_n)
    rd_status.empty |=> $stable(rd_bin)
  );

  // the write side samples this pointer, so only one bit may move at a time.
  a_rd_gray_step: assert property (
    @(posedge rd_clk) disable iff (!rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1
  );

endmodule

/* async_fifo/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo (
  input  logic            wr_clk,
  input  logic            rd_clk,
  input  logic            rst_n,
  input  logic            wr_en,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_en,
  output fifo_pkg::data_t rd_data,
  output logic            full,
  output logic            afull,
  output logic            empty,
  output logic            aempty
);

  logic                            wr_vld;
  logic [fifo_pkg::addr_width-1:0] wr_addr;
  fifo_pkg::ptr_t                  wr_gray;
  fifo_pkg::wr_status_t            wr_status;

  logic                            rd_vld;
  logic [fifo_pkg::addr_width-1:0] rd_addr;
  fifo_pkg::ptr_t                  rd_gray;
  fifo_pkg::rd_status_t            rd_status;

  // write domain.
  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk    (wr_clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .rd_gray   (rd_gray),
    .wr_vld    (wr_vld),
    .wr_addr   (wr_addr),
    .wr_gray   (wr_gray),
    .wr_status (wr_status)
  );

  // read domain.
  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk    (rd_clk),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .wr_gray   (wr_gray),
    .rd_vld    (rd_vld),
    .rd_addr   (rd_addr),
    .rd_gray   (rd_gray),
    .rd_status (rd_status)
  );

  dual_port_ram u_ram (
    .wr_clk  (wr_clk),
    .wr_vld  (wr_vld),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rst_n   (rst_n),
    .rd_vld  (rd_vld),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  assign full   = wr_status.full;
  assign afull  = wr_status.afull;
  assign empty  = rd_status.empty;
  assign aempty = rd_status.aempty;

endmodule

/* testbench/tb_async_fifo.sv */
`timescale 1ns/1ps

module tb_async_fifo;

  typedef struct packed {
    int   n_wr;
    int   n_rd;
    logic overlap;
    logic rnd;
    logic exp_afull;
    logic exp_aempty;
  } step_t;

  localparam int max_steps = 16;

  logic            wr_clk;
  logic            rd_clk;
  logic            rst_n;
  logic            wr_en;
  logic            rd_en;
  fifo_pkg::data_t wr_data;
  fifo_pkg::data_t rd_data;
  logic            full;
  logic            afull;
  logic            empty;
  logic            aempty;

  step_t           step_tab [max_steps];
  string           step_name [max_steps];
  int              n_steps;
  int              seed;
  int              err_cnt;
  int              pass_cnt;
  int              fail_cnt;
  int              cycle_cnt;
  int              cycle_limit = 0;
  logic            wr_busy;
  logic            rd_pend;
  logic            just_filled;
  fifo_pkg::data_t rd_exp;
  fifo_pkg::data_t model_q [$];

  async_fifo u_dut (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .full    (full),
    .afull   (afull),
    .empty   (empty),
    .aempty  (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #2 wr_clk = ~wr_clk;
  end

  // offset by half a ns so that rd edges and both drive times stay apart from wr edges.
  initial begin
    rd_clk = 1'b0;
    #0.5;
    forever #3 rd_clk = ~rd_clk;
  end

  // the rising edge after this negedge takes a write if wr_en is high and full is low.
  always @(negedge wr_clk) begin
    if (just_filled && !full) begin
      $display("Mismatch at %0t: full low after the write that filled the FIFO", $time);
      err_cnt++;
    end
    just_filled = 1'b0;
    if (wr_en && !full) begin
      model_q.push_back(wr_data);
      just_filled = (model_q.size() == fifo_pkg::fifo_depth);
    end
  end

  // rd_data from the previous accepted read is stable here.
  always @(negedge rd_clk) begin
    if (rd_pend) begin
      if (rd_data !== rd_exp) begin
        $display("Mismatch at %0t: read data expected %h got %h", $time, rd_exp, rd_data);
        err_cnt++;
      end
      rd_pend = 1'b0;
    end
    if (rd_en && !empty) begin
      if (model_q.size() == 0) begin
        $display("read accepted at %0t while the model queue was empty", $time);
        err_cnt++;
      end else begin
        rd_exp  = model_q.pop_front();
        rd_pend = 1'b1;
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge wr_clk);
      cycle_cnt++;
    end
    $display("timeout: simulation did not finish");
    $display("Errors found");
    $finish;
  end

  task automatic add_step(input string name, input int n_wr, input int n_rd,
                          input logic overlap, input logic rnd,
                          input logic exp_afull, input logic exp_aempty);
    step_name[n_steps] = name;
    step_tab[n_steps]  = '{n_wr, n_rd, overlap, rnd, exp_afull, exp_aempty};
    n_steps++;
  endtask

  function automatic int limit_from_table();
    int sum;
    sum = 0;
    for (int i = 0; i < n_steps; i++) begin
      sum += step_tab[i].n_wr + step_tab[i].n_rd;
    end
    return sum * 4 + 200;
  endfunction

  task automatic write_burst(input int idx, input int n, input logic rnd);
    int r;
    for (int i = 0; i < n; i++) begin
      @(posedge wr_clk);
      #1;
      r       = $random(seed);
      wr_en   = rnd ? r[0] : 1'b1;
      wr_data = fifo_pkg::data_t'(r[15:8]) ^ fifo_pkg::data_t'(idx);
    end
    @(posedge wr_clk);
    #1;
    wr_en = 1'b0;
  endtask

  // holds rd_en until n reads have been taken.
  task automatic read_accepted(input int n);
    int got;
    got = 0;
    if (n > 0) begin
      @(posedge rd_clk);
      #1;
      rd_en = 1'b1;
      while (got < n) begin
        @(negedge rd_clk);
        if (!empty) got++;
      end
      @(posedge rd_clk);
      #1;
      rd_en = 1'b0;
    end
  endtask

  task automatic random_reads();
    int r;
    while (wr_busy) begin
      @(posedge rd_clk);
      #1;
      r     = $random(seed);
      rd_en = r[0];
    end
    // writer has stopped, so read until the model is empty.
    rd_en = 1'b1;
    while (model_q.size() != 0) begin
      @(posedge rd_clk);
      #1;
    end
    rd_en = 1'b0;
  endtask

  task automatic expect_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
      err_cnt++;
    end
  endtask

  task automatic check_flags(input logic exp_afull, input logic exp_aempty);
    int n;
    n = model_q.size();
    expect_bit("afull", afull, exp_afull);
    expect_bit("aempty", aempty, exp_aempty);
    expect_bit("full", full, n == fifo_pkg::fifo_depth);
    expect_bit("empty", empty, n == 0);
  endtask

  task automatic report_step(input string name, input int err_before);
    if (err_cnt == err_before) begin
      $display("step %s: pass", name);
      pass_cnt++;
    end else begin
      $display("step %s: fail with %0d errors", name, err_cnt - err_before);
      fail_cnt++;
    end
  endtask

  task automatic run_step(input int idx);
    step_t s;
    int    err_before;
    s          = step_tab[idx];
    err_before = err_cnt;
    if (s.rnd) begin
      wr_busy = 1'b1;
      fork
        begin
          write_burst(idx, s.n_wr, 1'b1);
          wr_busy = 1'b0;
        end
        random_reads();
      join
    end else if (s.overlap) begin
      fork
        write_burst(idx, s.n_wr, 1'b0);
        read_accepted(s.n_rd);
      join
    end else begin
      write_burst(idx, s.n_wr, 1'b0);
      read_accepted(s.n_rd);
    end
    // let both pointers cross before the flags are judged.
    repeat (10) @(negedge rd_clk);
    check_flags(s.exp_afull, s.exp_aempty);
    report_step(step_name[idx], err_before);
  endtask

  initial begin
    int err_before;
    rst_n       = 1'b0;
    wr_en       = 1'b0;
    rd_en       = 1'b0;
    wr_data     = '0;
    seed        = 32'hc292_2a8a;
    err_cnt     = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    n_steps     = 0;
    wr_busy     = 1'b0;
    rd_pend     = 1'b0;
    just_filled = 1'b0;
    rd_exp      = '0;

    // name, writes, reads, overlap, random, afull, aempty.
    add_step("fill_1",     1,  0, 1'b0, 1'b0, 1'b0, 1'b1);
    add_step("fill_2",     1,  0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_step("fill_14",   12,  0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_step("fill_15",    1,  0, 1'b0, 1'b0, 1'b1, 1'b0);
    add_step("fill_16",    1,  0, 1'b0, 1'b0, 1'b1, 1'b0);
    add_step("overflow",   1,  0, 1'b0, 1'b0, 1'b1, 1'b0);
    add_step("drain_16",   0, 16, 1'b0, 1'b0, 1'b0, 1'b1);
    add_step("order",      8,  8, 1'b1, 1'b0, 1'b0, 1'b1);
    add_step("random",   300,  0, 1'b1, 1'b1, 1'b0, 1'b1);
    cycle_limit = limit_from_table();

    repeat (8) @(posedge rd_clk);
    #1;
    rst_n = 1'b1;

    err_before = err_cnt;
    repeat (3) @(negedge rd_clk);
    expect_bit("empty after reset", empty, 1'b1);
    expect_bit("aempty after reset", aempty, 1'b1);
    expect_bit("full after reset", full, 1'b0);
    expect_bit("afull after reset", afull, 1'b0);
    if (rd_data !== '0) begin
      $display("Mismatch at %0t: rd_data after reset expected 00 got %h", $time, rd_data);
      err_cnt++;
    end
    report_step("reset", err_before);

    for (int i = 0; i < n_steps; i++) begin
      run_step(i);
    end

    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* async_fifo.f */
common/fifo_pkg.sv
rtl/dual_port_ram.sv
async_fifo/fifo_wr_ctrl.sv
async_fifo/fifo_rd_ctrl.sv
async_fifo/async_fifo.sv
testbench/tb_async_fifo.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module tb_async_fifo \
  -f async_fifo.f -o tb_async_fifo > build.log 2>&1 \
  && ./obj_dir/tb_async_fifo > sim.log 2>&1 \
  || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -qx "No errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
